// File: hw/cmd_defines.svh
`ifndef CMD_DEFINES_SVH
`define CMD_DEFINES_SVH

// command ids as seen in the message stream.
`define CMD_GET_VERSION     5'd0
`define CMD_GET_TIME        5'd2
`define CMD_SET_DIGITAL_OUT 5'd15
`define CMD_SHUTDOWN        5'd19
`define CMD_BITS            5

// response ids, sent as the raw first byte.
`define RSP_GET_VERSION     8'd0
`define RSP_GET_TIME        8'd1

`define ARG_BITS            32      // argument and returned value width.
`define MAX_ARGS            8       // argument store depth.
`define MAX_PARAMS          8       // returned value store depth.
`define LEN_BITS            8       // send FIFO entry width.

`define NGPIO               8
`define FW_VERSION          32'd262

`endif

// File: hw/cmd_pkg.sv
`default_nettype none

`include "cmd_defines.svh"

package cmd_pkg;

	// which unit owns a command.
	typedef enum logic [1:0] {
		UNIT_NONE,
		UNIT_SYSTEM,
		UNIT_GPIO
	} unit_id_t;

	typedef struct packed {
		logic valid;
		unit_id_t unit;
		logic [$clog2(`MAX_ARGS)-1:0] nargs;
		logic has_response;
	} cmd_entry_t;

	// sequencer to unit.
	typedef struct packed {
		logic [`CMD_BITS-1:0] cmd;
		logic cmd_ready;                // one cycle start.
		logic [`ARG_BITS-1:0] arg_data; // current argument.
	} unit_req_t;

	// unit back to sequencer.
	typedef struct packed {
		logic arg_advance;
		logic param_write;
		logic cmd_done;                   // exactly once per command.
		logic [`ARG_BITS-1:0] param_data; // response id in the cmd_done cycle.
	} unit_rsp_t;

endpackage

`default_nettype wire

// File: hw/cmd_table.sv
`default_nettype none

`include "cmd_defines.svh"

module cmd_table import cmd_pkg::*; (
	input wire logic [`CMD_BITS-1:0] cmd,
	output cmd_entry_t entry
);

always_comb begin
	entry = '{valid: 1'b0, unit: UNIT_NONE, nargs: '0, has_response: 1'b0};
	case (cmd)
	`CMD_GET_VERSION:
		entry = '{valid: 1'b1, unit: UNIT_SYSTEM, nargs: 3'd0, has_response: 1'b1};
	`CMD_GET_TIME:
		entry = '{valid: 1'b1, unit: UNIT_SYSTEM, nargs: 3'd0, has_response: 1'b1};
	`CMD_SET_DIGITAL_OUT:
		entry = '{valid: 1'b1, unit: UNIT_GPIO, nargs: 3'd2, has_response: 1'b0};
	`CMD_SHUTDOWN:
		entry = '{valid: 1'b1, unit: UNIT_SYSTEM, nargs: 3'd0, has_response: 1'b0};
	default: ; // unknown ids stay invalid.
	endcase
end

endmodule

`default_nettype wire

// File: hw/vlq_decoder.sv
`default_nettype none

`include "cmd_defines.svh"

module vlq_decoder import cmd_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic [7:0] msg_data,
	input wire logic msg_ready,
	output logic msg_rd_en,
	input wire logic busy,
	output logic cmd_start,
	output logic [`CMD_BITS-1:0] cmd,
	output cmd_entry_t entry,
	input wire logic [$clog2(`MAX_ARGS)-1:0] arg_index,
	output logic [`ARG_BITS-1:0] arg_value
);

typedef enum logic [1:0] {
	DEC_IDLE,
	DEC_ARG_START,
	DEC_ARG_CONT
} dec_state_t;

dec_state_t state;
cmd_entry_t tab_entry;
logic [`ARG_BITS-1:0] args [`MAX_ARGS];
logic [$clog2(`MAX_ARGS)-1:0] arg_cnt;
logic rd;
logic arg_end;

cmd_table u_cmd_table (
	.cmd(msg_data[`CMD_BITS-1:0]),
	.entry(tab_entry)
);

assign rd = msg_ready && !msg_rd_en && !busy && !cmd_start;
assign arg_end = (state != DEC_IDLE) && !msg_data[7];
assign arg_value = args[arg_index];

always_ff @(posedge clk) begin
	if (reset) begin
		state <= DEC_IDLE;
		msg_rd_en <= 1'b0;
		cmd_start <= 1'b0;
		arg_cnt <= '0;
	end else begin
		msg_rd_en <= rd;
		cmd_start <= 1'b0;
		if (rd) begin
			case (state)
			DEC_IDLE: begin
				cmd <= msg_data[`CMD_BITS-1:0];
				entry <= tab_entry;
				arg_cnt <= '0;
				if (tab_entry.valid && tab_entry.unit != UNIT_NONE) begin
					if (tab_entry.nargs == 0)
						cmd_start <= 1'b1;
					else
						state <= DEC_ARG_START;
				end
			end
			DEC_ARG_START: begin
				// sign fill only when bits 6 and 5 are both set.
				args[arg_cnt] <= {{(`ARG_BITS-7){msg_data[6] & msg_data[5]}},
					msg_data[6:0]};
				if (msg_data[7])
					state <= DEC_ARG_CONT;
			end
			default: begin
				args[arg_cnt] <= {args[arg_cnt][`ARG_BITS-8:0], msg_data[6:0]};
			end
			endcase
			if (arg_end) begin
				arg_cnt <= arg_cnt + 1'b1;
				if (arg_cnt + 1'b1 == entry.nargs) begin
					cmd_start <= 1'b1;
					state <= DEC_IDLE;
				end else begin
					state <= DEC_ARG_START;
				end
			end
		end
	end
end

a_rd_spaced: assert property (@(posedge clk) disable iff (reset)
	msg_rd_en |=> !msg_rd_en);

// no reads while the sequencer holds busy.
a_no_rd_busy: assert property (@(posedge clk) disable iff (reset)
	busy |-> !msg_rd_en);

endmodule

`default_nettype wire

// File: hw/cmd_sequencer.sv
`default_nettype none

`include "cmd_defines.svh"

module cmd_sequencer import cmd_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic cmd_start,
	input wire logic [`CMD_BITS-1:0] cmd,
	input wire cmd_entry_t entry,
	output logic [$clog2(`MAX_ARGS)-1:0] arg_index,
	input wire logic [`ARG_BITS-1:0] arg_value,
	output unit_req_t sys_req,
	output unit_req_t gpio_req,
	input wire unit_rsp_t sys_rsp,
	input wire unit_rsp_t gpio_rsp,
	output logic param_push,
	output logic [`ARG_BITS-1:0] param_value,
	output logic rsp_start,
	output logic [7:0] rsp_id,
	input wire logic rsp_busy,
	output logic busy
);

typedef enum logic [1:0] {
	SEQ_IDLE,
	SEQ_RUN,
	SEQ_START,
	SEQ_WAIT
} seq_state_t;

seq_state_t state;
unit_id_t sel;
logic has_rsp;
logic [`CMD_BITS-1:0] cmd_q;
logic [`ARG_BITS-1:0] arg_data;
logic cmd_ready;
unit_rsp_t rsp_sel;

assign rsp_sel = (sel == UNIT_GPIO) ? gpio_rsp : sys_rsp;

assign sys_req = '{cmd: cmd_q, cmd_ready: cmd_ready && sel == UNIT_SYSTEM,
	arg_data: arg_data};
assign gpio_req = '{cmd: cmd_q, cmd_ready: cmd_ready && sel == UNIT_GPIO,
	arg_data: arg_data};

assign param_push = (state == SEQ_RUN) && rsp_sel.param_write;
assign param_value = rsp_sel.param_data;

always_ff @(posedge clk) begin
	if (reset) begin
		state <= SEQ_IDLE;
		sel <= UNIT_NONE;
		has_rsp <= 1'b0;
		arg_index <= '0;
		cmd_ready <= 1'b0;
		rsp_start <= 1'b0;
		busy <= 1'b0;
	end else begin
		cmd_ready <= 1'b0;
		rsp_start <= 1'b0;
		case (state)
		SEQ_IDLE: begin
			if (cmd_start) begin
				sel <= entry.unit;
				has_rsp <= entry.has_response;
				cmd_q <= cmd;
				arg_data <= arg_value; // index is 0 here.
				arg_index <= 1;
				cmd_ready <= 1'b1;
				busy <= 1'b1;
				state <= SEQ_RUN;
			end
		end
		SEQ_RUN: begin
			if (rsp_sel.arg_advance) begin
				arg_data <= arg_value;
				arg_index <= arg_index + 1'b1;
			end
			if (rsp_sel.cmd_done) begin
				arg_index <= '0;
				if (has_rsp) begin
					rsp_start <= 1'b1;
					rsp_id <= rsp_sel.param_data[7:0];
					state <= SEQ_START;
				end else begin
					busy <= 1'b0;
					state <= SEQ_IDLE;
				end
			end
		end
		SEQ_START: state <= SEQ_WAIT; // encoder picks up rsp_start.
		default: begin
			if (!rsp_busy) begin
				busy <= 1'b0;
				state <= SEQ_IDLE;
			end
		end
		endcase
	end
end

a_sys_done_sel: assert property (@(posedge clk) disable iff (reset)
	sys_rsp.cmd_done |-> state == SEQ_RUN && sel == UNIT_SYSTEM);

a_gpio_done_sel: assert property (@(posedge clk) disable iff (reset)
	gpio_rsp.cmd_done |-> state == SEQ_RUN && sel == UNIT_GPIO);

endmodule

`default_nettype wire

// File: hw/response_encoder.sv
`default_nettype none

`include "cmd_defines.svh"

module response_encoder (
	input wire logic clk,
	input wire logic reset,
	input wire logic param_push,
	input wire logic [`ARG_BITS-1:0] param_value,
	input wire logic rsp_start,
	input wire logic [7:0] rsp_id,
	output logic rsp_busy,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	output logic [`LEN_BITS-1:0] send_fifo_data,
	output logic send_fifo_wr_en
);

localparam int VLQ_BITS = 35; // five 7 bit groups.
localparam int CNT_BITS = $clog2(`MAX_PARAMS) + 1;

typedef enum logic [1:0] {
	ENC_IDLE,
	ENC_LOAD,
	ENC_SKIP,
	ENC_SEND
} enc_state_t;

enc_state_t state;
logic [`ARG_BITS-1:0] params [`MAX_PARAMS];
logic [CNT_BITS-1:0] nparams;
logic [CNT_BITS-1:0] cur;
logic [VLQ_BITS-1:0] rcv;
logic [2:0] grp;
logic [`LEN_BITS-1:0] rsp_len;
logic can_drop;
logic emit;

assign rsp_busy = (state != ENC_IDLE);

// top group redundant when the next one reproduces it on decode.
assign can_drop = (grp != 0) &&
	(rcv[VLQ_BITS-1:VLQ_BITS-9] == 9'h1ff || rcv[VLQ_BITS-1:VLQ_BITS-9] < 9'd3);
assign emit = (state == ENC_SEND) || (state == ENC_SKIP && !can_drop);

always_ff @(posedge clk) begin
	if (reset) begin
		state <= ENC_IDLE;
		nparams <= '0;
		cur <= '0;
		grp <= '0;
		send_ring_wr_en <= 1'b0;
		send_fifo_wr_en <= 1'b0;
	end else begin
		send_ring_wr_en <= 1'b0;
		send_fifo_wr_en <= 1'b0;
		if (param_push) begin
			params[nparams[CNT_BITS-2:0]] <= param_value;
			nparams <= nparams + 1'b1;
		end
		case (state)
		ENC_IDLE: begin
			if (rsp_start) begin
				send_ring_data <= rsp_id; // id byte goes out raw.
				send_ring_wr_en <= 1'b1;
				rsp_len <= 1;
				cur <= '0;
				if (nparams == 0) begin
					send_fifo_data <= 1;
					send_fifo_wr_en <= 1'b1;
				end else begin
					state <= ENC_LOAD;
				end
			end
		end
		ENC_LOAD: begin
			rcv <= {{(VLQ_BITS-`ARG_BITS){params[cur[CNT_BITS-2:0]][`ARG_BITS-1]}},
				params[cur[CNT_BITS-2:0]]};
			grp <= 3'd4;
			state <= ENC_SKIP;
		end
		ENC_SKIP: begin
			if (can_drop) begin
				grp <= grp - 1'b1;
				rcv <= {rcv[VLQ_BITS-8:0], 7'b0};
			end
		end
		default: ;
		endcase
		if (emit) begin
			send_ring_data <= {grp != 0, rcv[VLQ_BITS-1:VLQ_BITS-7]};
			send_ring_wr_en <= 1'b1;
			rsp_len <= rsp_len + 1'b1;
			grp <= grp - 1'b1;
			rcv <= {rcv[VLQ_BITS-8:0], 7'b0};
			state <= ENC_SEND;
			if (grp == 0) begin
				if (cur + 1'b1 != nparams) begin
					cur <= cur + 1'b1;
					state <= ENC_LOAD;
				end else begin
					send_fifo_data <= rsp_len + 1'b1; // includes this byte.
					send_fifo_wr_en <= 1'b1;
					nparams <= '0;
					state <= ENC_IDLE;
				end
			end
		end
	end
end

a_nparams_max: assert property (@(posedge clk) disable iff (reset)
	nparams <= `MAX_PARAMS);

endmodule

`default_nettype wire

// File: hw/system_unit.sv
`default_nettype none

`include "cmd_defines.svh"

module system_unit import cmd_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire unit_req_t req,
	output unit_rsp_t rsp,
	input wire logic [31:0] systime,
	output logic shutdown
);

typedef enum logic [1:0] {
	SYS_IDLE,
	SYS_VER,
	SYS_FIN
} sys_state_t;

sys_state_t state;
logic param_write;
logic cmd_done;
logic [`ARG_BITS-1:0] param_data;
logic [7:0] rsp_id;

assign rsp = '{arg_advance: 1'b0, param_write: param_write, cmd_done: cmd_done,
	param_data: param_data};

always_ff @(posedge clk) begin
	if (reset) begin
		state <= SYS_IDLE;
		param_write <= 1'b0;
		cmd_done <= 1'b0;
		shutdown <= 1'b0;
	end else begin
		param_write <= 1'b0;
		cmd_done <= 1'b0;
		case (state)
		SYS_IDLE: begin
			if (req.cmd_ready) begin
				case (req.cmd)
				`CMD_GET_VERSION: begin
					param_data <= `FW_VERSION;
					param_write <= 1'b1;
					state <= SYS_VER;
				end
				`CMD_GET_TIME: begin
					param_data <= systime; // sampled with cmd_ready.
					param_write <= 1'b1;
					rsp_id <= `RSP_GET_TIME;
					state <= SYS_FIN;
				end
				`CMD_SHUTDOWN: begin
					shutdown <= 1'b1; // sticky until reset.
					cmd_done <= 1'b1;
				end
				default: cmd_done <= 1'b1;
				endcase
			end
		end
		SYS_VER: begin
			param_data <= `NGPIO;
			param_write <= 1'b1;
			rsp_id <= `RSP_GET_VERSION;
			state <= SYS_FIN;
		end
		default: begin
			param_data <= {{(`ARG_BITS-8){1'b0}}, rsp_id};
			cmd_done <= 1'b1;
			state <= SYS_IDLE;
		end
		endcase
	end
end

endmodule

`default_nettype wire

// File: hw/gpio_unit.sv
`default_nettype none

`include "cmd_defines.svh"

module gpio_unit import cmd_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire unit_req_t req,
	output unit_rsp_t rsp,
	input wire logic shutdown,
	output logic [`NGPIO-1:0] gpio
);

typedef enum logic [1:0] {
	GP_IDLE,
	GP_ADV,
	GP_VAL
} gp_state_t;

gp_state_t state;
logic arg_advance;
logic cmd_done;
logic [`ARG_BITS-1:0] chan;

assign rsp = '{arg_advance: arg_advance, param_write: 1'b0, cmd_done: cmd_done,
	param_data: '0};

always_ff @(posedge clk) begin
	if (reset) begin
		state <= GP_IDLE;
		arg_advance <= 1'b0;
		cmd_done <= 1'b0;
		gpio <= '0;
	end else begin
		arg_advance <= 1'b0;
		cmd_done <= 1'b0;
		case (state)
		GP_IDLE: begin
			if (req.cmd_ready) begin
				if (req.cmd == `CMD_SET_DIGITAL_OUT) begin
					chan <= req.arg_data;
					arg_advance <= 1'b1;
					state <= GP_ADV;
				end else begin
					cmd_done <= 1'b1;
				end
			end
		end
		GP_ADV: state <= GP_VAL; // value shows up next cycle.
		default: begin
			if (!shutdown && chan < `NGPIO)
				gpio[chan[$clog2(`NGPIO)-1:0]] <= req.arg_data[0];
			cmd_done <= 1'b1;
			state <= GP_IDLE;
		end
		endcase
		if (shutdown)
			gpio <= '0;
	end
end

endmodule

`default_nettype wire

// File: hw/command_top.sv
`default_nettype none

`include "cmd_defines.svh"

module command_top import cmd_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic [7:0] msg_data,
	input wire logic msg_ready,
	output logic msg_rd_en,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	output logic [`LEN_BITS-1:0] send_fifo_data,
	output logic send_fifo_wr_en,
	input wire logic [31:0] systime,
	output logic [`NGPIO-1:0] gpio
);

logic cmd_start;
logic [`CMD_BITS-1:0] cmd;
cmd_entry_t entry;
logic [$clog2(`MAX_ARGS)-1:0] arg_index;
logic [`ARG_BITS-1:0] arg_value;
logic busy;
unit_req_t sys_req;
unit_req_t gpio_req;
unit_rsp_t sys_rsp;
unit_rsp_t gpio_rsp;
logic param_push;
logic [`ARG_BITS-1:0] param_value;
logic rsp_start;
logic [7:0] rsp_id;
logic rsp_busy;
logic shutdown;

vlq_decoder u_decoder (
	.clk(clk),
	.reset(reset),
	.msg_data(msg_data),
	.msg_ready(msg_ready),
	.msg_rd_en(msg_rd_en),
	.busy(busy),
	.cmd_start(cmd_start),
	.cmd(cmd),
	.entry(entry),
	.arg_index(arg_index),
	.arg_value(arg_value)
);

cmd_sequencer u_sequencer (
	.clk(clk),
	.reset(reset),
	.cmd_start(cmd_start),
	.cmd(cmd),
	.entry(entry),
	.arg_index(arg_index),
	.arg_value(arg_value),
	.sys_req(sys_req),
	.gpio_req(gpio_req),
	.sys_rsp(sys_rsp),
	.gpio_rsp(gpio_rsp),
	.param_push(param_push),
	.param_value(param_value),
	.rsp_start(rsp_start),
	.rsp_id(rsp_id),
	.rsp_busy(rsp_busy),
	.busy(busy)
);

response_encoder u_encoder (
	.clk(clk),
	.reset(reset),
	.param_push(param_push),
	.param_value(param_value),
	.rsp_start(rsp_start),
	.rsp_id(rsp_id),
	.rsp_busy(rsp_busy),
	.send_ring_data(send_ring_data),
	.send_ring_wr_en(send_ring_wr_en),
	.send_fifo_data(send_fifo_data),
	.send_fifo_wr_en(send_fifo_wr_en)
);

system_unit u_system (
	.clk(clk),
	.reset(reset),
	.req(sys_req),
	.rsp(sys_rsp),
	.systime(systime),
	.shutdown(shutdown)
);

gpio_unit u_gpio (
	.clk(clk),
	.reset(reset),
	.req(gpio_req),
	.rsp(gpio_rsp),
	.shutdown(shutdown),
	.gpio(gpio)
);

endmodule

`default_nettype wire

// File: testbench/tb_command.sv
`default_nettype none

`include "cmd_defines.svh"

module tb_command;

localparam int TIME_CMDS = 19;
localparam int GPIO_CMDS = 24;
localparam int N_CMDS = 1 + TIME_CMDS + GPIO_CMDS + 2 + 4;
localparam int CMD_CYCLES = 80; // longest message with gaps plus a 5 byte response.
localparam int CYCLE_LIMIT = 10 + 30 + N_CMDS * CMD_CYCLES;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic clk = 1'b0;
logic reset;
logic [7:0] msg_data;
logic msg_ready;
logic msg_rd_en;
logic [7:0] send_ring_data;
logic send_ring_wr_en;
logic [`LEN_BITS-1:0] send_fifo_data;
logic send_fifo_wr_en;
logic [31:0] systime;
logic [`NGPIO-1:0] gpio;

logic [31:0] lfsr = 32'd75906;
logic [7:0] msg_q [$];
logic [7:0] exp_ring_q [$];
logic [`LEN_BITS-1:0] exp_len_q [$];
logic [7:0] exp_byte;
logic exp_ring_ok;
logic [`LEN_BITS-1:0] exp_len;
logic exp_len_ok;
logic [`NGPIO-1:0] exp_gpio;
logic gpio_check;
logic shutdown_sent;
int ring_cnt = 0;
int errors = 0;
int err_mark = 0;
int tests_run = 0;
int tests_failed = 0;
int time_vals [TIME_CMDS] = '{95, 96, -32, -33, 12287, 12288, -4096, -4097,
	1572863, 1572864, -524288, -524289, 201326591, 201326592, -67108864,
	-67108865, 0, 32'h7fffffff, 32'h80000000};

command_top u_dut (
	.clk(clk),
	.reset(reset),
	.msg_data(msg_data),
	.msg_ready(msg_ready),
	.msg_rd_en(msg_rd_en),
	.send_ring_data(send_ring_data),
	.send_ring_wr_en(send_ring_wr_en),
	.send_fifo_data(send_fifo_data),
	.send_fifo_wr_en(send_fifo_wr_en),
	.systime(systime),
	.gpio(gpio)
);

always #4 clk = ~clk;

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic b;
	r = '0;
	for (int i = 0; i < n; i++) begin
		b = lfsr[0];
		lfsr = (lfsr >> 1) ^ (b ? LFSR_TAPS : 32'd0);
		r = {r[30:0], b};
	end
	return r;
endfunction

function automatic void report_mismatch(input string name, input logic [31:0] exp,
	input logic [31:0] act);
	$display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
	errors++;
endfunction

function automatic void report_error(input string msg);
	$display("ERROR %0t %s", $time, msg);
	errors++;
endfunction

// shortest group count whose sign extension gives back the value.
function automatic int vlq_len(input logic [31:0] v);
	longint s;
	s = longint'($signed(v));
	if (s >= -32 && s <= 95)
		return 1;
	if (s >= -4096 && s <= 12287)
		return 2;
	if (s >= -524288 && s <= 1572863)
		return 3;
	if (s >= -67108864 && s <= 201326591)
		return 4;
	return 5;
endfunction

task automatic append_vlq(ref logic [7:0] q[$], input logic [31:0] v, input int n);
	logic [34:0] sx;
	sx = {{3{v[31]}}, v};
	for (int g = n - 1; g >= 0; g--)
		q.push_back({g != 0, sx[g*7 +: 7]}); // msb group first.
endtask

task automatic expect_response(input logic [7:0] id, input int nvals,
	input logic [31:0] v0, input logic [31:0] v1);
	logic [31:0] v;
	int len;
	exp_ring_q.push_back(id);
	len = 1;
	for (int i = 0; i < nvals; i++) begin
		v = (i == 0) ? v0 : v1;
		append_vlq(exp_ring_q, v, vlq_len(v));
		len += vlq_len(v);
	end
	exp_len_q.push_back(len[`LEN_BITS-1:0]);
endtask

task automatic wait_idle();
	do
		@(negedge clk);
	while (msg_q.size() != 0 || msg_rd_en || u_dut.cmd_start || u_dut.busy);
endtask

task automatic check_gpio();
	@(negedge clk);
	gpio_check = 1'b1;
	@(negedge clk);
	gpio_check = 1'b0;
endtask

task automatic send_set_out(input logic [31:0] ch, input logic [31:0] val,
	input int n_ch, input int n_val);
	msg_q.push_back({3'b0, `CMD_SET_DIGITAL_OUT});
	append_vlq(msg_q, ch, n_ch);
	append_vlq(msg_q, val, n_val);
	if (!shutdown_sent && ch < `NGPIO)
		exp_gpio[ch[2:0]] = val[0];
	wait_idle();
	check_gpio();
endtask

task automatic run_get_time(input logic [31:0] t);
	@(negedge clk);
	systime = t; // held until the response is out.
	expect_response(`RSP_GET_TIME, 1, t, 32'd0);
	msg_q.push_back({3'b0, `CMD_GET_TIME});
	wait_idle();
endtask

task automatic run_get_version();
	expect_response(`RSP_GET_VERSION, 2, `FW_VERSION, `NGPIO);
	msg_q.push_back({3'b0, `CMD_GET_VERSION});
	wait_idle();
endtask

task automatic run_shutdown();
	msg_q.push_back({3'b0, `CMD_SHUTDOWN});
	shutdown_sent = 1'b1;
	exp_gpio = '0;
	wait_idle();
	check_gpio();
endtask

task automatic end_test(input string name);
	assert (exp_ring_q.size() == 0 && exp_len_q.size() == 0)
		else report_error("expected response bytes were not all written");
	tests_run++;
	if (errors != err_mark)
		tests_failed++;
	$display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
	err_mark = errors;
endtask

// next byte of the source shows up after a read.
always @(negedge clk) begin
	if (msg_rd_en && msg_q.size() > 0)
		void'(msg_q.pop_front());
	if (msg_q.size() > 0) begin
		msg_data = msg_q[0];
		msg_ready = rand_bits(2) != 0; // random gaps.
	end else begin
		msg_ready = 1'b0;
	end
end

always @(posedge clk) begin
	if (send_ring_wr_en && exp_ring_q.size() > 0)
		void'(exp_ring_q.pop_front());
	if (send_fifo_wr_en && exp_len_q.size() > 0)
		void'(exp_len_q.pop_front());
	if (send_fifo_wr_en)
		ring_cnt <= 0;
	else if (send_ring_wr_en)
		ring_cnt <= ring_cnt + 1;
end

always @(negedge clk) begin
	exp_ring_ok = exp_ring_q.size() > 0;
	exp_byte = exp_ring_ok ? exp_ring_q[0] : 8'h00;
	exp_len_ok = exp_len_q.size() > 0;
	exp_len = exp_len_ok ? exp_len_q[0] : '0;
end

a_reset_quiet: assert property (@(posedge clk) reset |=> !msg_rd_en && !send_ring_wr_en
	&& !send_fifo_wr_en && !u_dut.sys_req.cmd_ready && !u_dut.gpio_req.cmd_ready
	&& !u_dut.busy && !u_dut.shutdown && gpio == '0)
	else report_error("outputs not quiet during reset");

a_ring_expected: assert property (@(posedge clk) disable iff (reset)
	send_ring_wr_en |-> exp_ring_ok)
	else report_error("ring byte written with no response pending");

a_ring_byte: assert property (@(posedge clk) disable iff (reset)
	send_ring_wr_en && exp_ring_ok |-> send_ring_data == exp_byte)
	else report_mismatch("send_ring_data", $sampled(exp_byte), $sampled(send_ring_data));

a_fifo_expected: assert property (@(posedge clk) disable iff (reset)
	send_fifo_wr_en |-> exp_len_ok)
	else report_error("send FIFO written with no response pending");

a_fifo_len: assert property (@(posedge clk) disable iff (reset)
	send_fifo_wr_en && exp_len_ok |-> send_fifo_data == exp_len)
	else report_mismatch("send_fifo_data", $sampled(exp_len), $sampled(send_fifo_data));

// length must also match what actually went into the ring.
a_fifo_count: assert property (@(posedge clk) disable iff (reset)
	send_fifo_wr_en |-> send_fifo_data == ring_cnt + 1)
	else report_mismatch("send_fifo_data", $sampled(ring_cnt) + 1, $sampled(send_fifo_data));

a_gpio_value: assert property (@(posedge clk) disable iff (reset)
	gpio_check |-> gpio == exp_gpio)
	else report_mismatch("gpio", $sampled(exp_gpio), $sampled(gpio));

a_gpio_shutdown: assert property (@(posedge clk) disable iff (reset)
	u_dut.shutdown |=> gpio == '0)
	else report_mismatch("gpio", 32'd0, $sampled(gpio));

initial begin : watchdog
	int cycles;
	cycles = 0;
	while (cycles < CYCLE_LIMIT) begin
		@(posedge clk);
		cycles++;
	end
	$display("timeout after %0d cycles, a command never finished", cycles);
	$display("Simulation failed");
	$finish;
end

initial begin
	logic [31:0] ch;
	logic [31:0] val;
	int n_ch;
	int n_val;
	reset = 1'b1;
	msg_data = 8'h00;
	msg_ready = 1'b0;
	systime = 32'd0;
	gpio_check = 1'b0;
	exp_gpio = '0;
	shutdown_sent = 1'b0;
	repeat (10) @(posedge clk);
	@(negedge clk);
	reset = 1'b0;

	repeat (3) @(negedge clk);
	check_gpio();
	end_test("after reset");

	run_get_version();
	end_test("get_version");

	for (int i = 0; i < TIME_CMDS; i++)
		run_get_time(time_vals[i]);
	end_test("get_time encoding");

	// channels -2..13, values of every length, padded forms too.
	for (int i = 0; i < GPIO_CMDS; i++) begin
		ch = rand_bits(4) - 32'd2;
		val = $signed(rand_bits(32)) >>> rand_bits(5);
		n_ch = vlq_len(ch) + rand_bits(2);
		n_val = vlq_len(val) + rand_bits(2);
		if (n_ch > 5)
			n_ch = 5;
		if (n_val > 5)
			n_val = 5;
		send_set_out(ch, val, n_ch, n_val);
	end
	end_test("set_digital_out decoding");

	msg_q.push_back(8'd5);
	msg_q.push_back(8'd31);
	msg_q.push_back(8'h2c);
	send_set_out(32'd3, 32'd1, 1, 1);
	run_get_version();
	end_test("unknown ids");

	run_shutdown();
	send_set_out(32'd1, 32'd1, 1, 1);
	send_set_out(32'd3, 32'd1, 2, 3);
	run_get_time(32'hffff_f000);
	end_test("shutdown");

	$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
	if (errors == 0)
		$display("Simulation completed successfully");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/cmd_pkg.sv
hw/cmd_table.sv
hw/vlq_decoder.sv
hw/cmd_sequencer.sv
hw/response_encoder.sv
hw/system_unit.sv
hw/gpio_unit.sv
hw/command_top.sv
testbench/tb_command.sv

// File: Bender.yml
package:
  name: command_front_end

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cmd_pkg.sv
      - hw/cmd_table.sv
      - hw/vlq_decoder.sv
      - hw/cmd_sequencer.sv
      - hw/response_encoder.sv
      - hw/system_unit.sv
      - hw/gpio_unit.sv
      - hw/command_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_command.sv
